// File: source/simd_alu.sv
// SIMD execution pipeline.
// Stage 1 registers the operands and the operation, stage 2 registers
// the result picked from the lane adders, the shifter or the bitwise
// logic. A result leaves two cycles after its issue.
`timescale 1ns/1ns

module simd_alu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  simd_pkg::simd_op_t    issue_op,
  input  simd_pkg::lane_size_t  issue_size,
  input  simd_pkg::simd_word_t  issue_a,
  input  simd_pkg::simd_word_t  issue_b,
  output logic                  res_valid,
  output simd_pkg::simd_word_t  res_data
);
  import simd_pkg::*;

  logic            v1;
  simd_op_t        op_q;
  lane_size_t      size_q;
  simd_word_t      a_q;
  simd_word_t      b_q;
  simd_word_t      sh_res;
  wire simd_word_t add_res [4]; // lane adder results for each lane size.

  always_ff @(posedge clk) begin
    a_q <= issue_a;
    b_q <= issue_b;
    if (rst) begin
      v1 <= 1'b0;
      op_q <= op_padd;
      size_q <= lane_8;
    end else begin
      v1 <= issue_valid;
      if (issue_valid) begin
        op_q <= issue_op;
        size_q <= issue_size;
      end
    end
  end

  // eight 8-bit, four 16-bit, two 32-bit and one 64-bit lane adder.
  for (genvar w = 8; w <= $bits(simd_word_t); w = w * 2) begin : g_size
    for (genvar l = 0; l < $bits(simd_word_t) / w; l++) begin : g_lane
      simd_lane_add #(.width(w)) u_add (
        .a   (a_q[l*w +: w]),
        .b   (b_q[l*w +: w]),
        .op  (op_q),
        .res (add_res[$clog2(w)-3][l*w +: w])
      );
    end
  end

  simd_shift u_shift (
    .a    (a_q),
    .b    (b_q),
    .op   (op_q),
    .size (size_q),
    .res  (sh_res)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= v1;
    end
    case (op_q)
      op_pand: res_data <= a_q & b_q;
      op_por: res_data <= a_q | b_q;
      op_pxor: res_data <= a_q ^ b_q;
      op_pshl, op_pshr, op_psar: res_data <= sh_res;
      default: res_data <= add_res[size_q]; // lane adder gives zero for unused codes.
    endcase
  end

  a_size_known: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> !$isunknown(issue_size))
    else $error("issue with unknown lane size");

endmodule

// File: source/simd_lane_add.sv
// SIMD lane adder.
// One lane of add, subtract, saturation, min, max and compare.
// A single adder serves every operation and the carry out and the
// signed overflow pick the final lane value.
`timescale 1ns/1ns

module simd_lane_add #(
  parameter int width = 16
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  input  simd_pkg::simd_op_t op,
  output logic [width-1:0] res
);
  import simd_pkg::*;

  logic             sub;
  logic [width-1:0] bx;
  logic [width:0]   sum;
  logic             ovf;
  logic             lt_u;
  logic             lt_s;
  logic             eq;
  logic [width-1:0] sat_pos;

  // everything except the three additions runs a minus b.
  assign sub = !(op inside {op_padd, op_paddsat, op_paddsats});
  assign bx = sub ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, bx} + {{width{1'b0}}, sub};

  // both inputs agree in sign but the sum does not.
  assign ovf = (a[width-1] == bx[width-1]) && (sum[width-1] != a[width-1]);

  assign lt_u = !sum[width]; // no carry out of a minus b is a borrow.
  assign lt_s = sum[width-1] ^ ovf;
  assign eq = (a == b);
  assign sat_pos = {1'b0, {(width-1){1'b1}}};

  always_comb begin
    case (op)
      op_padd, op_psub: res = sum[width-1:0];
      op_paddsat: res = sum[width] ? '1 : sum[width-1:0];
      op_psubsat: res = sum[width] ? sum[width-1:0] : '0;
      op_paddsats, op_psubsats: begin
        // on overflow the sign of a tells which end was crossed.
        if (ovf) begin
          res = a[width-1] ? ~sat_pos : sat_pos;
        end else begin
          res = sum[width-1:0];
        end
      end
      op_pminu: res = lt_u ? a : b;
      op_pmaxu: res = lt_u ? b : a;
      op_pmins: res = lt_s ? a : b;
      op_pmaxs: res = lt_s ? b : a;
      op_pcmpeq: res = {width{eq}};
      op_pcmpgt: res = {width{!lt_s && !eq}}; // signed a greater than b.
      default: res = '0; // bitwise, shift and unused codes are handled elsewhere.
    endcase
  end

  // the operation held by the pipeline stage must be a defined code.
  a_legal_op: assert final ($isunknown(op) || op <= op_psar)
    else $error("lane adder sees unused operation code %0d", op);

endmodule

// File: source/simd_pkg.sv
// SIMD unit shared definitions.
// Operation and lane size encodings, bus and datapath types,
// the bus register map and the sizing constants of the unit.
package simd_pkg;

  typedef enum logic [4:0] {
    op_padd,
    op_psub,
    op_paddsat,
    op_psubsat,
    op_paddsats,
    op_psubsats,
    op_pminu,
    op_pmaxu,
    op_pmins,
    op_pmaxs,
    op_pcmpeq,
    op_pcmpgt,
    op_pand,
    op_por,
    op_pxor,
    op_pshl,
    op_pshr,
    op_psar
  } simd_op_t; // codes above op_psar give a zero result.

  typedef enum logic [1:0] {lane_8, lane_16, lane_32, lane_64} lane_size_t;

  typedef logic [63:0] simd_word_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [2:0]  wb_addr_t;
  typedef logic [3:0]  fifo_level_t; // holds 0 to fifo_depth.

  localparam wb_addr_t reg_a_lo   = 3'd0;
  localparam wb_addr_t reg_a_hi   = 3'd1;
  localparam wb_addr_t reg_b_lo   = 3'd2;
  localparam wb_addr_t reg_b_hi   = 3'd3;
  localparam wb_addr_t reg_op     = 3'd4; // writing here issues an operation.
  localparam wb_addr_t reg_res_lo = 3'd5;
  localparam wb_addr_t reg_res_hi = 3'd6; // reading here pops the result.
  localparam wb_addr_t reg_status = 3'd7;

  localparam int op_field_lsb   = 0;
  localparam int size_field_lsb = 8;

  localparam int fifo_depth  = 8;
  localparam int alu_latency = 2;

endpackage

// File: source/simd_result_fifo.sv
// SIMD result FIFO.
// Circular buffer of 64-bit results with a fill level. The head entry
// is read combinationally, push and pop may happen in one cycle.
`timescale 1ns/1ns

module simd_result_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  simd_pkg::simd_word_t  push_data,
  input  logic                  pop,
  output simd_pkg::simd_word_t  head_data,
  output logic                  empty,
  output simd_pkg::fifo_level_t level
);
  import simd_pkg::*;

  simd_word_t                    mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;

  assign head_data = mem[rd_ptr];
  assign empty = (level == '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
    end else begin
      wr_ptr <= wr_ptr + push; // pointers wrap with the power of two depth.
      rd_ptr <= rd_ptr + pop;
      level <= level + fifo_level_t'(push) - fifo_level_t'(pop);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> level != fifo_level_t'(fifo_depth))
    else $error("push into a full result FIFO");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("pop from an empty result FIFO");

endmodule

// File: source/simd_shift.sv
// SIMD lane shifter.
// Shifts every lane of a by the low bits of the matching lane of b,
// left, logical right or arithmetic right, for all four lane sizes.
`timescale 1ns/1ns

module simd_shift (
  input  simd_pkg::simd_word_t a,
  input  simd_pkg::simd_word_t b,
  input  simd_pkg::simd_op_t   op,
  input  simd_pkg::lane_size_t size,
  output simd_pkg::simd_word_t res
);
  import simd_pkg::*;

  logic            is_sar;
  logic            is_shift;
  wire simd_word_t by_size [4]; // one shifted word per lane size.

  assign is_sar = (op == op_psar);
  assign is_shift = op inside {op_pshl, op_pshr, op_psar};

  for (genvar w = 8; w <= $bits(simd_word_t); w = w * 2) begin : g_size
    for (genvar l = 0; l < $bits(simd_word_t) / w; l++) begin : g_lane
      wire [w-1:0]          la  = a[l*w +: w];
      wire [$clog2(w)-1:0]  amt = b[l*w +: $clog2(w)];
      // the upper half carries the fill bits shifted in from the left.
      wire [2*w-1:0]        ext = {{w{is_sar & la[w-1]}}, la} >> amt;

      assign by_size[$clog2(w)-3][l*w +: w] = (op == op_pshl) ? la << amt : ext[w-1:0];
    end
  end

  assign res = is_shift ? by_size[size] : '0;

endmodule

// File: source/simd_unit_top.sv
// SIMD execution unit.
// Connects the bus registers, the execution pipeline and the result FIFO.
`timescale 1ns/1ns

module simd_unit_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  simd_pkg::wb_addr_t wb_adr,
  input  simd_pkg::wb_data_t wb_dat_w,
  output simd_pkg::wb_data_t wb_dat_r,
  output logic               wb_ack
);
  import simd_pkg::*;

  logic        issue_valid;
  simd_op_t    issue_op;
  lane_size_t  issue_size;
  simd_word_t  issue_a;
  simd_word_t  issue_b;
  logic        res_valid;
  simd_word_t  res_data;
  logic        pop;
  simd_word_t  head_data;
  logic        empty;
  fifo_level_t level;

  simd_wb_regs u_regs (
    .clk (clk), .rst (rst),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .issue_valid (issue_valid), .issue_op (issue_op), .issue_size (issue_size),
    .issue_a (issue_a), .issue_b (issue_b), .res_valid (res_valid),
    .head_data (head_data), .empty (empty), .level (level), .pop (pop)
  );

  simd_alu u_alu (
    .clk (clk), .rst (rst),
    .issue_valid (issue_valid), .issue_op (issue_op), .issue_size (issue_size),
    .issue_a (issue_a), .issue_b (issue_b),
    .res_valid (res_valid), .res_data (res_data)
  );

  simd_result_fifo u_fifo (
    .clk (clk), .rst (rst),
    .push (res_valid), .push_data (res_data), .pop (pop),
    .head_data (head_data), .empty (empty), .level (level)
  );

endmodule

// File: source/simd_wb_regs.sv
// SIMD unit bus registers.
// Wishbone classic slave holding the operand and operation registers.
// It issues operations, stalls them while the results could not fit,
// and returns results and status to the host.
`timescale 1ns/1ns

module simd_wb_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  simd_pkg::wb_addr_t    wb_adr,
  input  simd_pkg::wb_data_t    wb_dat_w,
  output simd_pkg::wb_data_t    wb_dat_r,
  output logic                  wb_ack,
  output logic                  issue_valid,
  output simd_pkg::simd_op_t    issue_op,
  output simd_pkg::lane_size_t  issue_size,
  output simd_pkg::simd_word_t  issue_a,
  output simd_pkg::simd_word_t  issue_b,
  input  logic                  res_valid,
  input  simd_pkg::simd_word_t  head_data,
  input  logic                  empty,
  input  simd_pkg::fifo_level_t level,
  output logic                  pop
);
  import simd_pkg::*;

  fifo_level_t in_flight; // operations issued but not yet in the FIFO.
  logic        req;
  logic        is_op_wr;
  logic        has_space;
  logic        accept;
  wb_data_t    rd_word;

  assign req = wb_cyc && wb_stb && !wb_ack; // the ack cycle closes the request.
  assign is_op_wr = wb_we && (wb_adr == reg_op);
  assign has_space = (level + in_flight) < fifo_level_t'(fifo_depth);
  assign accept = req && (!is_op_wr || has_space);

  always_comb begin
    rd_word = '0;
    case (wb_adr)
      reg_a_lo: rd_word = issue_a[31:0];
      reg_a_hi: rd_word = issue_a[63:32];
      reg_b_lo: rd_word = issue_b[31:0];
      reg_b_hi: rd_word = issue_b[63:32];
      reg_op: begin
        rd_word[op_field_lsb +: $bits(simd_op_t)] = issue_op;
        rd_word[size_field_lsb +: $bits(lane_size_t)] = issue_size;
      end
      reg_res_lo: rd_word = empty ? '0 : head_data[31:0];
      reg_res_hi: rd_word = empty ? '0 : head_data[63:32];
      default: rd_word[$bits(fifo_level_t)-1:0] = level;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      issue_valid <= 1'b0;
      pop <= 1'b0;
      in_flight <= '0;
    end else begin
      wb_ack <= accept;
      issue_valid <= accept && is_op_wr;
      pop <= accept && !wb_we && (wb_adr == reg_res_hi) && !empty;
      in_flight <= in_flight + fifo_level_t'(issue_valid) - fifo_level_t'(res_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_dat_r <= rd_word;
      if (wb_we) begin
        case (wb_adr)
          reg_a_lo: issue_a[31:0] <= wb_dat_w;
          reg_a_hi: issue_a[63:32] <= wb_dat_w;
          reg_b_lo: issue_b[31:0] <= wb_dat_w;
          reg_b_hi: issue_b[63:32] <= wb_dat_w;
          reg_op: begin
            issue_op <= simd_op_t'(wb_dat_w[op_field_lsb +: $bits(simd_op_t)]);
            issue_size <= lane_size_t'(wb_dat_w[size_field_lsb +: $bits(lane_size_t)]);
          end
          default: ; // result and status registers ignore writes.
        endcase
      end
    end
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_cyc && wb_stb)
    else $error("ack outside a bus cycle");

  a_in_flight: assert property (@(posedge clk) disable iff (rst) in_flight <= alu_latency)
    else $error("more operations in flight than pipeline stages");

endmodule

// File: test/simd_model.svh
// SIMD unit reference model.
// Computes the expected 64-bit result of an operation lane by lane,
// with wide arithmetic so that carries and saturation are exact.
`ifndef SIMD_MODEL_SVH
`define SIMD_MODEL_SVH

function automatic simd_word_t lane_mask(int w);
  return (w >= 64) ? '1 : ((64'd1 << w) - 64'd1);
endfunction

// clamps a wide signed value to the range of a w-bit lane.
function automatic simd_word_t saturate_signed(logic signed [65:0] s, int w);
  logic signed [65:0] hi;
  logic signed [65:0] lo;
  hi = (66'sd1 <<< (w - 1)) - 66'sd1;
  lo = -(66'sd1 <<< (w - 1));
  if (s > hi) begin
    s = hi;
  end else if (s < lo) begin
    s = lo;
  end
  return simd_word_t'(s) & lane_mask(w);
endfunction

// one lane, with the operands in the low w bits of a and b.
function automatic simd_word_t lane_result(simd_op_t op, int w, simd_word_t a, simd_word_t b);
  simd_word_t         mask;
  logic [65:0]        ua;
  logic [65:0]        ub;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  int                 amt;
  mask = lane_mask(w);
  ua = {2'b00, a & mask};
  ub = {2'b00, b & mask};
  sa = $signed(ua);
  sb = $signed(ub);
  if (a[w-1]) sa = sa - (66'sd1 <<< w); // negative lanes are sign extended.
  if (b[w-1]) sb = sb - (66'sd1 <<< w);
  amt = int'(b & simd_word_t'(w - 1));
  case (op)
    op_padd: return simd_word_t'(ua + ub) & mask;
    op_psub: return simd_word_t'(ua - ub) & mask;
    op_paddsat: return ((ua + ub) > {2'b00, mask}) ? mask : simd_word_t'(ua + ub);
    op_psubsat: return (ua < ub) ? '0 : simd_word_t'(ua - ub);
    op_paddsats: return saturate_signed(sa + sb, w);
    op_psubsats: return saturate_signed(sa - sb, w);
    op_pminu: return simd_word_t'((ua < ub) ? ua : ub);
    op_pmaxu: return simd_word_t'((ua > ub) ? ua : ub);
    op_pmins: return simd_word_t'((sa < sb) ? ua : ub);
    op_pmaxs: return simd_word_t'((sa > sb) ? ua : ub);
    op_pcmpeq: return (ua == ub) ? mask : '0;
    op_pcmpgt: return (sa > sb) ? mask : '0;
    op_pand: return a & b & mask;
    op_por: return (a | b) & mask;
    op_pxor: return (a ^ b) & mask;
    op_pshl: return (ua[63:0] << amt) & mask;
    op_pshr: return ua[63:0] >> amt;
    op_psar: return simd_word_t'(sa >>> amt) & mask;
    default: return '0;
  endcase
endfunction

function automatic simd_word_t expected_result(simd_op_t op, lane_size_t size,
                                               simd_word_t a, simd_word_t b);
  int         w;
  simd_word_t r;
  w = 8 << int'(size);
  r = '0;
  for (int l = 0; l < 64 / w; l++) begin
    r = r | ((lane_result(op, w, a >> (l * w), b >> (l * w)) & lane_mask(w)) << (l * w));
  end
  return r;
endfunction

`endif

// File: test/simd_unit_tb.sv
// SIMD unit testbench.
// Runs random operations through the Wishbone port and checks each result
// against the lane model, then covers FIFO back-pressure, ordering and reset.
`timescale 1ns/1ns

module simd_unit_tb;
  import simd_pkg::*;

  `include "simd_model.svh"

  localparam int n_arith = 64;
  localparam int n_cmp = 48;
  localparam int n_logic = 48;
  localparam int n_order = 12;
  localparam int n_misc = 4;
  localparam int total_ops = n_arith + n_cmp + n_logic + n_order + n_misc;
  localparam int clk_period = 8;

  logic     clk = 1'b0;
  logic     rst;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic     wb_ack;

  int         checks;
  int         errors;
  simd_word_t exp_q[$]; // expected results in issue order.
  string      desc_q[$];

  simd_unit_top uut (
    .clk (clk), .rst (rst),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(string name, simd_word_t exp, simd_word_t got);
    checks++;
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // one bus cycle; max_wait of zero waits for the ack without a limit.
  task automatic bus_cycle(bit we, wb_addr_t adr, wb_data_t wdata, int max_wait,
                           output bit acked, output wb_data_t rdata);
    int n;
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    acked = 1'b0;
    rdata = '0;
    n = 0;
    while (!acked && (max_wait == 0 || n < max_wait)) begin
      @(posedge clk);
      #1;
      n++;
      if (wb_ack) begin
        acked = 1'b1;
        rdata = wb_dat_r;
      end
    end
    // the cycle ends on the clock edge where the slave sees its own ack.
    if (acked) begin
      @(posedge clk);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic bus_write(wb_addr_t adr, wb_data_t data);
    bit       acked;
    wb_data_t unused;
    bus_cycle(1'b1, adr, data, 0, acked, unused);
  endtask

  task automatic bus_read(wb_addr_t adr, output wb_data_t data);
    bit acked;
    bus_cycle(1'b0, adr, '0, 0, acked, data);
  endtask

  function automatic wb_data_t op_word(simd_op_t op, lane_size_t size);
    wb_data_t w;
    w = '0;
    w[op_field_lsb +: $bits(simd_op_t)] = op;
    w[size_field_lsb +: $bits(lane_size_t)] = size;
    return w;
  endfunction

  task automatic load_operands(simd_word_t a, simd_word_t b);
    bus_write(reg_a_lo, a[31:0]);
    bus_write(reg_a_hi, a[63:32]);
    bus_write(reg_b_lo, b[31:0]);
    bus_write(reg_b_hi, b[63:32]);
  endtask

  task automatic record_expected(simd_op_t op, lane_size_t size, simd_word_t a, simd_word_t b);
    exp_q.push_back(expected_result(op, size, a, b));
    desc_q.push_back($sformatf("reg_res (%s, %s)", op.name(), size.name()));
  endtask

  task automatic issue(simd_op_t op, lane_size_t size, simd_word_t a, simd_word_t b);
    load_operands(a, b);
    bus_write(reg_op, op_word(op, size));
    record_expected(op, size, a, b);
  endtask

  // polls the status register until the FIFO holds the wanted count.
  task automatic wait_level(int want);
    wb_data_t d;
    for (int i = 0; i < 16; i++) begin
      bus_read(reg_status, d);
      if (d == wb_data_t'(want)) break;
    end
    check_value("reg_status", simd_word_t'(want), simd_word_t'(d));
  endtask

  task automatic check_next_result();
    wb_data_t   lo;
    wb_data_t   hi;
    simd_word_t exp;
    string      name;
    bus_read(reg_res_lo, lo);
    bus_read(reg_res_hi, hi);
    if (exp_q.size() == 0) begin
      $display("at %0t ns a result was read back with none outstanding", $time);
      errors++;
    end else begin
      exp = exp_q.pop_front();
      name = desc_q.pop_front();
      check_value(name, exp, {hi, lo});
    end
  endtask

  task automatic run_one(simd_op_t op, lane_size_t size, simd_word_t a, simd_word_t b);
    issue(op, size, a, b);
    wait_level(1);
    check_next_result();
  endtask

  // lanes lean toward zero, all ones and the signed limits.
  function automatic simd_word_t edge_word(lane_size_t size);
    int         w;
    simd_word_t mask;
    simd_word_t lane;
    simd_word_t r;
    w = 8 << int'(size);
    mask = lane_mask(w);
    r = '0;
    for (int l = 0; l < 64 / w; l++) begin
      case ($urandom_range(0, 5))
        0: lane = '0;
        1: lane = mask;
        2: lane = mask >> 1;
        3: lane = (mask >> 1) + 64'd1;
        4: lane = 64'd1;
        default: lane = {$urandom(), $urandom()};
      endcase
      r = r | ((lane & mask) << (l * w));
    end
    return r;
  endfunction

  function automatic simd_word_t with_equal_lanes(lane_size_t size, simd_word_t a, simd_word_t b);
    int         w;
    simd_word_t m;
    w = 8 << int'(size);
    for (int l = 0; l < 64 / w; l++) begin
      m = lane_mask(w) << (l * w);
      if ($urandom_range(0, 2) == 0) b = (b & ~m) | (a & m);
    end
    return b;
  endfunction

  function automatic simd_op_t any_op();
    return simd_op_t'($urandom_range(0, int'(op_psar)));
  endfunction

  task automatic report_test(string name, int c0, int e0);
    $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic test_arith();
    simd_op_t   ops[6] = '{op_padd, op_psub, op_paddsat, op_psubsat, op_paddsats, op_psubsats};
    lane_size_t size;
    int         c0;
    int         e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < n_arith; i++) begin
      size = lane_size_t'(i % 4);
      run_one(ops[$urandom_range(0, 5)], size, edge_word(size), edge_word(size));
    end
    report_test("1 add and subtract", c0, e0);
  endtask

  task automatic test_compare();
    simd_op_t   ops[6] = '{op_pminu, op_pmaxu, op_pmins, op_pmaxs, op_pcmpeq, op_pcmpgt};
    lane_size_t size;
    simd_word_t a;
    int         c0;
    int         e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < n_cmp; i++) begin
      size = lane_size_t'(i % 4);
      a = edge_word(size);
      run_one(ops[$urandom_range(0, 5)], size, a, with_equal_lanes(size, a, edge_word(size)));
    end
    report_test("2 min, max and compare", c0, e0);
  endtask

  task automatic test_logic();
    simd_op_t   ops[6] = '{op_pand, op_por, op_pxor, op_pshl, op_pshr, op_psar};
    lane_size_t size;
    int         c0;
    int         e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < n_logic; i++) begin
      size = lane_size_t'(i % 4);
      run_one(ops[$urandom_range(0, 5)], size, edge_word(size), {$urandom(), $urandom()});
    end
    report_test("3 bitwise and shifts", c0, e0);
  endtask

  task automatic test_order();
    simd_op_t   op;
    lane_size_t size;
    simd_word_t a;
    simd_word_t b;
    wb_data_t   d;
    bit         acked;
    int         c0;
    int         e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < fifo_depth; i++) begin
      size = lane_size_t'($urandom_range(0, 3));
      issue(any_op(), size, edge_word(size), edge_word(size));
    end
    wait_level(fifo_depth);
    for (int i = fifo_depth; i < n_order; i++) begin
      op = any_op();
      size = lane_size_t'($urandom_range(0, 3));
      a = edge_word(size);
      b = edge_word(size);
      load_operands(a, b);
      bus_cycle(1'b1, reg_op, op_word(op, size), 12, acked, d); // full, so it must stall.
      checks++;
      assert (!acked) else begin
        $display("at %0t ns a reg_op write completed while the result FIFO was full", $time);
        errors++;
      end
      bus_read(reg_status, d);
      check_value("reg_status", simd_word_t'(fifo_depth), simd_word_t'(d));
      check_next_result();
      bus_write(reg_op, op_word(op, size));
      record_expected(op, size, a, b);
      wait_level(fifo_depth);
    end
    for (int i = 0; i < fifo_depth; i++) begin
      check_next_result();
    end
    report_test("4 ordering and back-pressure", c0, e0);
  endtask

  task automatic test_empty_and_reset();
    wb_data_t   d;
    lane_size_t size;
    int         c0;
    int         e0;
    c0 = checks;
    e0 = errors;
    bus_read(reg_res_hi, d);
    check_value("reg_res_hi", '0, simd_word_t'(d));
    bus_read(reg_status, d);
    check_value("reg_status", '0, simd_word_t'(d));
    for (int i = 0; i < n_misc - 1; i++) begin
      size = lane_size_t'(i % 4);
      issue(any_op(), size, edge_word(size), edge_word(size));
    end
    wait_level(n_misc - 1);
    apply_reset();
    exp_q.delete(); // results in the unit are lost with the reset.
    desc_q.delete();
    bus_read(reg_status, d);
    check_value("reg_status", '0, simd_word_t'(d));
    run_one(op_padd, lane_16, edge_word(lane_16), edge_word(lane_16));
    report_test("5 empty read and reset", c0, e0);
  endtask

  initial begin
    void'($urandom(32'h4c0497c2));
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    checks = 0;
    errors = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    test_arith();
    test_compare();
    test_logic();
    test_order();
    test_empty_and_reset();
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // each operation needs well under forty cycles of bus traffic.
  initial begin
    #(total_ops * 40 * clk_period);
    $display("the run timed out at %0t ns before all tests finished", $time);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+test
source/simd_pkg.sv
source/simd_lane_add.sv
source/simd_shift.sv
source/simd_alu.sv
source/simd_result_fifo.sv
source/simd_wb_regs.sv
source/simd_unit_top.sv
test/simd_unit_tb.sv
